// ==== hdl/exec_pkg.sv ====
/*
 * Shared RV32I definitions for the execute slice: word and register
 * index types, the ALU and branch operation codes, the result select
 * and the major opcodes. Referenced by scoped name from each module.
 */

package exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_JAL,
		BR_JALR
	} br_op_t;

	typedef enum logic {
		RES_ALU,
		RES_LINK
	} result_sel_t;

	// Major opcodes of the supported instruction classes.
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

endpackage

// ==== hdl/instr_decoder.sv ====
/*
 * Combinational RV32I decoder for the execute slice. Produces register
 * indices, the sign-extended immediate, ALU and branch operations and
 * operand selects. Unsupported encodings are flagged illegal.
 */

`timescale 1ns/1ps

module instr_decoder (
	input  exec_pkg::word_t       instr,
	output exec_pkg::reg_idx_t    rs1,
	output exec_pkg::reg_idx_t    rs2,
	output exec_pkg::reg_idx_t    rd,
	output exec_pkg::word_t       imm,
	output exec_pkg::alu_op_t     alu_op,
	output exec_pkg::br_op_t      br_op,
	output exec_pkg::result_sel_t result_sel,
	output logic                  use_pc_a,
	output logic                  use_imm_b,
	output logic                  rd_write,
	output logic                  illegal
);

	exec_pkg::opcode_t opcode;
	exec_pkg::alu_op_t arith_op;
	exec_pkg::word_t   imm_i;
	exec_pkg::word_t   imm_u;
	exec_pkg::word_t   imm_b;
	exec_pkg::word_t   imm_j;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic              f7_zero;
	logic              f7_alt;
	logic              op_legal;
	logic              opimm_legal;
	logic              wr_req;

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	// ----------------------------------------
	// Immediate formats.
	// ----------------------------------------
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);

	// Only add/sub and srl/sra have an alternate funct7 in OP.
	assign op_legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
	assign opimm_legal = (funct3 == 3'b001) ? f7_zero :
	                     (funct3 == 3'b101) ? (f7_zero || f7_alt) : 1'b1;

	// Shared funct3 mapping for OP and OP-IMM.
	always_comb begin
		case (funct3)
			3'b000: arith_op = (opcode == exec_pkg::OPC_OP && funct7[5]) ?
			                   exec_pkg::ALU_SUB : exec_pkg::ALU_ADD;
			3'b001: arith_op = exec_pkg::ALU_SLL;
			3'b010: arith_op = exec_pkg::ALU_SLT;
			3'b011: arith_op = exec_pkg::ALU_SLTU;
			3'b100: arith_op = exec_pkg::ALU_XOR;
			3'b101: arith_op = funct7[5] ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
			3'b110: arith_op = exec_pkg::ALU_OR;
			default: arith_op = exec_pkg::ALU_AND;
		endcase
	end

	// ----------------------------------------
	// Control per major opcode.
	// ----------------------------------------
	always_comb begin
		imm        = imm_i;
		alu_op     = exec_pkg::ALU_ADD;
		br_op      = exec_pkg::BR_NONE;
		result_sel = exec_pkg::RES_ALU;
		use_pc_a   = 1'b0;
		use_imm_b  = 1'b0;
		wr_req     = 1'b0;
		illegal    = 1'b0;
		case (opcode)
			exec_pkg::OPC_OP: begin
				alu_op  = arith_op;
				wr_req  = 1'b1;
				illegal = !op_legal;
			end
			exec_pkg::OPC_OP_IMM: begin
				alu_op    = arith_op;
				use_imm_b = 1'b1;
				wr_req    = 1'b1;
				illegal   = !opimm_legal;
			end
			exec_pkg::OPC_LUI: begin
				imm       = imm_u;
				alu_op    = exec_pkg::ALU_PASS_B;
				use_imm_b = 1'b1;
				wr_req    = 1'b1;
			end
			exec_pkg::OPC_AUIPC: begin
				imm       = imm_u;
				use_pc_a  = 1'b1;
				use_imm_b = 1'b1;
				wr_req    = 1'b1;
			end
			exec_pkg::OPC_JAL: begin
				imm        = imm_j;
				br_op      = exec_pkg::BR_JAL;
				result_sel = exec_pkg::RES_LINK;
				wr_req     = 1'b1;
			end
			exec_pkg::OPC_JALR: begin
				br_op      = exec_pkg::BR_JALR;
				result_sel = exec_pkg::RES_LINK;
				wr_req     = 1'b1;
				illegal    = (funct3 != 3'b000);
			end
			exec_pkg::OPC_BRANCH: begin
				imm = imm_b;
				case (funct3)
					3'b000: br_op = exec_pkg::BR_BEQ;
					3'b001: br_op = exec_pkg::BR_BNE;
					3'b100: br_op = exec_pkg::BR_BLT;
					3'b101: br_op = exec_pkg::BR_BGE;
					3'b110: br_op = exec_pkg::BR_BLTU;
					3'b111: br_op = exec_pkg::BR_BGEU;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
		// An illegal encoding must not redirect.
		if (illegal) begin
			br_op = exec_pkg::BR_NONE;
		end
	end

	// x0 is never reported as a write target.
	assign rd_write = wr_req && !illegal && (rd != 5'd0);

endmodule

// ==== hdl/reg_file.sv ====
/*
 * RV32I integer register file. x0 reads as zero, two combinational read
 * ports, one write port on clk. A read of the register being written in
 * the same cycle returns the incoming data.
 */

`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr_en,
	input  exec_pkg::reg_idx_t addr_wr,
	input  exec_pkg::reg_idx_t addr_rd1,
	input  exec_pkg::reg_idx_t addr_rd2,
	input  exec_pkg::word_t    data_wr,
	output exec_pkg::word_t    data_rd1,
	output exec_pkg::word_t    data_rd2
);

	exec_pkg::word_t regs [1:31];
	logic            wr_hit1;
	logic            wr_hit2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && addr_wr != 5'd0) begin
			regs[addr_wr] <= data_wr;
		end
	end

	// Write bypass.
	assign wr_hit1 = wr_en && (addr_wr == addr_rd1);
	assign wr_hit2 = wr_en && (addr_wr == addr_rd2);

	assign data_rd1 = (addr_rd1 == 5'd0) ? '0 :
	                  wr_hit1            ? data_wr : regs[addr_rd1];
	assign data_rd2 = (addr_rd2 == 5'd0) ? '0 :
	                  wr_hit2            ? data_wr : regs[addr_rd2];

endmodule

// ==== hdl/int_alu.sv ====
/*
 * Combinational RV32I integer ALU. Operand a is rs1 or the PC, operand
 * b is rs2 or the immediate, both chosen by the top level.
 */

`timescale 1ns/1ps

module int_alu (
	input  exec_pkg::alu_op_t op,
	input  exec_pkg::word_t   a,
	input  exec_pkg::word_t   b,
	output exec_pkg::word_t   result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			exec_pkg::ALU_ADD:    result = a + b;
			exec_pkg::ALU_SUB:    result = a - b;
			exec_pkg::ALU_SLL:    result = a << shamt;
			exec_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
			exec_pkg::ALU_SLTU:   result = {31'b0, a < b};
			exec_pkg::ALU_XOR:    result = a ^ b;
			exec_pkg::ALU_SRL:    result = a >> shamt;
			exec_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
			exec_pkg::ALU_OR:     result = a | b;
			exec_pkg::ALU_AND:    result = a & b;
			exec_pkg::ALU_PASS_B: result = b;
			default:              result = '0;
		endcase
	end

endmodule

// ==== hdl/branch_unit.sv ====
/*
 * Branch and jump evaluation. Decides whether control leaves the
 * sequential path and computes where it goes.
 */

`timescale 1ns/1ps

module branch_unit (
	input  exec_pkg::br_op_t op,
	input  exec_pkg::word_t  rs1_data,
	input  exec_pkg::word_t  rs2_data,
	input  exec_pkg::word_t  imm,
	input  exec_pkg::word_t  pc,
	output logic             taken,
	output exec_pkg::word_t  target
);

	exec_pkg::word_t base;
	exec_pkg::word_t sum;
	logic            eq;
	logic            lt;
	logic            ltu;

	assign eq  = (rs1_data == rs2_data);
	assign lt  = ($signed(rs1_data) < $signed(rs2_data));
	assign ltu = (rs1_data < rs2_data);

	always_comb begin
		case (op)
			exec_pkg::BR_BEQ:  taken = eq;
			exec_pkg::BR_BNE:  taken = !eq;
			exec_pkg::BR_BLT:  taken = lt;
			exec_pkg::BR_BGE:  taken = !lt;
			exec_pkg::BR_BLTU: taken = ltu;
			exec_pkg::BR_BGEU: taken = !ltu;
			exec_pkg::BR_JAL:  taken = 1'b1;
			exec_pkg::BR_JALR: taken = 1'b1;
			default:           taken = 1'b0;
		endcase
	end

	// JALR is register relative, everything else PC relative.
	assign base = (op == exec_pkg::BR_JALR) ? rs1_data : pc;
	assign sum  = base + imm;

	assign target = (op == exec_pkg::BR_JALR) ? {sum[31:1], 1'b0} : sum;

endmodule

// ==== hdl/retire_stage.sv ====
/*
 * Retire register of the execute slice. Captures one record per accepted
 * instruction, holds it under back-pressure on the retire port and
 * drives the register file write as the record leaves.
 */

`timescale 1ns/1ps

module retire_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  logic                  retire_ready,
	input  logic                  taken,
	input  logic                  rd_write,
	input  logic                  illegal,
	input  exec_pkg::word_t       alu_result,
	input  exec_pkg::word_t       target,
	input  exec_pkg::word_t       pc,
	input  exec_pkg::result_sel_t result_sel,
	input  exec_pkg::reg_idx_t    rd,
	output logic                  instr_ready,
	output logic                  retire_valid,
	output logic                  retire_wr,
	output logic                  retire_redirect,
	output logic                  retire_illegal,
	output logic                  wr_en,
	output exec_pkg::reg_idx_t    retire_rd,
	output exec_pkg::reg_idx_t    addr_wr,
	output exec_pkg::word_t       retire_value,
	output exec_pkg::word_t       retire_next_pc,
	output exec_pkg::word_t       data_wr
);

	exec_pkg::word_t link_pc;
	logic            accept;
	logic            leave;

	assign leave       = retire_valid && retire_ready;
	// Free when empty or draining this cycle.
	assign instr_ready = !retire_valid || retire_ready;
	assign accept      = instr_valid && instr_ready;

	assign link_pc = pc + 32'd4;

	// ----------------------------------------
	// Record control.
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid    <= 1'b0;
			retire_wr       <= 1'b0;
			retire_redirect <= 1'b0;
			retire_illegal  <= 1'b0;
		end else if (accept) begin
			retire_valid    <= 1'b1;
			retire_wr       <= rd_write;
			retire_redirect <= taken;
			retire_illegal  <= illegal;
		end else if (leave) begin
			retire_valid <= 1'b0;
		end
	end

	// Record payload.
	always_ff @(posedge clk) begin
		if (accept) begin
			retire_rd      <= rd;
			retire_value   <= (result_sel == exec_pkg::RES_LINK) ? link_pc : alu_result;
			retire_next_pc <= taken ? target : link_pc;
		end
	end

	// Write back on the departing edge.
	assign wr_en   = leave && retire_wr;
	assign addr_wr = retire_rd;
	assign data_wr = retire_value;

endmodule

// ==== hdl/exec_core.sv ====
/*
 * Top level of the RV32I integer execute slice. Takes instructions on a
 * valid/ready port, executes them in one combinational stage and offers
 * one retire record per instruction on a second valid/ready port.
 */

`timescale 1ns/1ps

module exec_core (
	input  logic               clk,
	input  logic               rst_n,
	// Instruction port.
	input  logic               instr_valid,
	output logic               instr_ready,
	input  exec_pkg::word_t    instr_word,
	input  exec_pkg::word_t    instr_pc,
	// Retire port.
	output logic               retire_valid,
	input  logic               retire_ready,
	output exec_pkg::reg_idx_t retire_rd,
	output exec_pkg::word_t    retire_value,
	output logic               retire_wr,
	output exec_pkg::word_t    retire_next_pc,
	output logic               retire_redirect,
	output logic               retire_illegal
);

	exec_pkg::reg_idx_t    rs1;
	exec_pkg::reg_idx_t    rs2;
	exec_pkg::reg_idx_t    rd;
	exec_pkg::reg_idx_t    addr_wr;
	exec_pkg::word_t       imm;
	exec_pkg::word_t       rs1_data;
	exec_pkg::word_t       rs2_data;
	exec_pkg::word_t       alu_a;
	exec_pkg::word_t       alu_b;
	exec_pkg::word_t       alu_result;
	exec_pkg::word_t       target;
	exec_pkg::word_t       data_wr;
	exec_pkg::alu_op_t     alu_op;
	exec_pkg::br_op_t      br_op;
	exec_pkg::result_sel_t result_sel;
	logic                  use_pc_a;
	logic                  use_imm_b;
	logic                  rd_write;
	logic                  illegal;
	logic                  taken;
	logic                  wr_en;

	// ----------------------------------------
	// Decode and operand read.
	// ----------------------------------------
	instr_decoder u_decoder (
		.instr      (instr_word),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.imm        (imm),
		.alu_op     (alu_op),
		.br_op      (br_op),
		.result_sel (result_sel),
		.use_pc_a   (use_pc_a),
		.use_imm_b  (use_imm_b),
		.rd_write   (rd_write),
		.illegal    (illegal)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.addr_wr  (addr_wr),
		.addr_rd1 (rs1),
		.addr_rd2 (rs2),
		.data_wr  (data_wr),
		.data_rd1 (rs1_data),
		.data_rd2 (rs2_data)
	);

	// ----------------------------------------
	// Execute.
	// ----------------------------------------
	assign alu_a = use_pc_a  ? instr_pc : rs1_data;
	assign alu_b = use_imm_b ? imm      : rs2_data;

	int_alu u_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result)
	);

	branch_unit u_branch (
		.op       (br_op),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.imm      (imm),
		.pc       (instr_pc),
		.taken    (taken),
		.target   (target)
	);

	retire_stage u_retire (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr_valid     (instr_valid),
		.retire_ready    (retire_ready),
		.taken           (taken),
		.rd_write        (rd_write),
		.illegal         (illegal),
		.alu_result      (alu_result),
		.target          (target),
		.pc              (instr_pc),
		.result_sel      (result_sel),
		.rd              (rd),
		.instr_ready     (instr_ready),
		.retire_valid    (retire_valid),
		.retire_wr       (retire_wr),
		.retire_redirect (retire_redirect),
		.retire_illegal  (retire_illegal),
		.wr_en           (wr_en),
		.retire_rd       (retire_rd),
		.addr_wr         (addr_wr),
		.retire_value    (retire_value),
		.retire_next_pc  (retire_next_pc),
		.data_wr         (data_wr)
	);

endmodule

// ==== test/tb_exec_core.sv ====
/*
 * Directed testbench for the RV32I execute slice. Sends instructions on
 * the instruction port, predicts each retire record with a register
 * model and checks the records as they leave the retire port.
 */

`timescale 1ns/1ps

module tb_exec_core;

	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] value;
		logic        wr;
		logic [31:0] next_pc;
		logic        redirect;
		logic        illegal;
	} rec_t;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic        instr_ready;
	logic [31:0] instr_word;
	logic [31:0] instr_pc;
	logic        retire_valid;
	logic        retire_ready;
	logic [4:0]  retire_rd;
	logic [31:0] retire_value;
	logic        retire_wr;
	logic [31:0] retire_next_pc;
	logic        retire_redirect;
	logic        retire_illegal;

	logic [31:0] xr [0:31];
	rec_t        exp_q [$];
	rec_t        held;
	rec_t        cur_exp;
	logic        held_valid;
	logic        bp_enable;
	logic [31:0] pc_next;
	int          stretch;
	int          checks;
	int          errors;
	int          timeouts;

	exec_core UUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr_valid     (instr_valid),
		.instr_ready     (instr_ready),
		.instr_word      (instr_word),
		.instr_pc        (instr_pc),
		.retire_valid    (retire_valid),
		.retire_ready    (retire_ready),
		.retire_rd       (retire_rd),
		.retire_value    (retire_value),
		.retire_wr       (retire_wr),
		.retire_next_pc  (retire_next_pc),
		.retire_redirect (retire_redirect),
		.retire_illegal  (retire_illegal)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// Reference model.
	// ----------------------------------------
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
	                                        input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b011: return {31'd0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt) return $signed(a) >>> sh;
				return a >> sh;
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
	                                    input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Predicts the record of one instruction and updates the model registers.
	function automatic rec_t predict(input logic [31:0] ins, input logic [31:0] pc);
		rec_t        r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] tgt;
		logic        tk;
		a     = xr[ins[19:15]];
		b     = xr[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_u = {ins[31:12], 12'h000};
		tk    = 1'b0;
		tgt   = pc + 32'd4;
		r     = '0;
		r.rd  = ins[11:7];
		r.wr  = 1'b1;
		case (ins[6:0])
			exec_pkg::OPC_OP:     r.value = alu_ref(ins[14:12], ins[30], a, b);
			exec_pkg::OPC_OP_IMM: r.value = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101,
			                                        a, imm_i);
			exec_pkg::OPC_LUI:    r.value = imm_u;
			exec_pkg::OPC_AUIPC:  r.value = pc + imm_u;
			exec_pkg::OPC_JAL: begin
				tk      = 1'b1;
				tgt     = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				r.value = pc + 32'd4;
			end
			exec_pkg::OPC_JALR: begin
				tk      = 1'b1;
				tgt     = (a + imm_i) & ~32'd1;
				r.value = pc + 32'd4;
			end
			exec_pkg::OPC_BRANCH: begin
				r.wr = 1'b0;
				tk   = branch_ref(ins[14:12], a, b);
				tgt  = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			default: begin
				r.wr      = 1'b0;
				r.illegal = 1'b1;
			end
		endcase
		if (r.rd == 5'd0) r.wr = 1'b0;
		if (r.wr) xr[r.rd] = r.value;
		r.redirect = tk;
		r.next_pc  = tk ? tgt : pc + 32'd4;
		return r;
	endfunction

	// ----------------------------------------
	// Encoders.
	// ----------------------------------------
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	                                      input logic [4:0] rs1, input logic [2:0] f3,
	                                      input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, exec_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	                                      input logic [2:0] f3, input logic [4:0] rd,
	                                      input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
	                                      input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], exec_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, exec_pkg::OPC_JAL};
	endfunction

	function automatic logic [4:0] rand_src();
		return 5'($urandom_range(1, 8));
	endfunction

	// ----------------------------------------
	// Checking and run control.
	// ----------------------------------------
	task automatic check_field(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s = 0x%h, expected 0x%h",
			         $time, name, actual, expected);
		end
	endtask

	task automatic compare_record(input string tag, input rec_t want, input logic with_data);
		if (with_data) begin
			check_field({tag, "retire_rd"}, 32'(retire_rd), 32'(want.rd));
			check_field({tag, "retire_value"}, retire_value, want.value);
		end
		check_field({tag, "retire_wr"}, 32'(retire_wr), 32'(want.wr));
		check_field({tag, "retire_next_pc"}, retire_next_pc, want.next_pc);
		check_field({tag, "retire_redirect"}, 32'(retire_redirect), 32'(want.redirect));
		check_field({tag, "retire_illegal"}, 32'(retire_illegal), 32'(want.illegal));
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	// Retire port monitor. A held record must not change while it waits.
	always @(posedge clk) begin
		if (rst_n && retire_valid) begin
			if (held_valid) begin
				compare_record("held ", held, 1'b1);
			end
			if (retire_ready) begin
				held_valid = 1'b0;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("A retire record left at %0t with no instruction outstanding",
					         $time);
				end
				if (exp_q.size() != 0) begin
					cur_exp = exp_q.pop_front();
					compare_record("", cur_exp, cur_exp.wr);
				end
			end else begin
				check_field("instr_ready", 32'(instr_ready), 32'd0);
				held.rd       = retire_rd;
				held.value    = retire_value;
				held.wr       = retire_wr;
				held.next_pc  = retire_next_pc;
				held.redirect = retire_redirect;
				held.illegal  = retire_illegal;
				held_valid    = 1'b1;
			end
		end
	end

	// Random stretches of retire back-pressure.
	always @(negedge clk) begin
		if (!bp_enable) begin
			retire_ready = 1'b1;
		end else if (stretch == 0) begin
			retire_ready = 1'($urandom_range(0, 1));
			stretch      = $urandom_range(0, 5);
		end else begin
			stretch--;
		end
	end

	// ----------------------------------------
	// Drivers.
	// ----------------------------------------
	task automatic send(input logic [31:0] ins);
		int   cycles;
		logic accepted;
		exp_q.push_back(predict(ins, pc_next));
		instr_word  = ins;
		instr_pc    = pc_next;
		instr_valid = 1'b1;
		cycles      = 0;
		accepted    = 1'b0;
		while (!accepted && cycles < 100) begin
			@(posedge clk);
			accepted = instr_ready;
			cycles++;
		end
		@(negedge clk);
		instr_valid = 1'b0;
		pc_next     = pc_next + 32'd4;
		if (!accepted) begin
			$display("Timeout: instruction 0x%h was never accepted", ins);
			timeouts++;
			finish_run();
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 1000) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d retire records never left the retire port", exp_q.size());
			timeouts++;
			finish_run();
		end
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		send({value[31:12] + value[11], rd, exec_pkg::OPC_LUI});
		send(enc_i(value[11:0], rd, 3'b000, rd, exec_pkg::OPC_OP_IMM));
	endtask

	// Reads every register back through add xr, xr, x0.
	task automatic check_regs();
		for (int r = 1; r < 32; r++) begin
			send(enc_r(7'h00, 5'd0, 5'(r), 3'b000, 5'(r)));
		end
		wait_drain();
	endtask

	// ----------------------------------------
	// Directed tests.
	// ----------------------------------------
	task automatic test_reset();
		check_field("retire_valid", 32'(retire_valid), 32'd0);
		check_field("instr_ready", 32'(instr_ready), 32'd1);
		check_regs();
	endtask

	task automatic test_arith();
		logic [11:0] imm;
		for (int r = 1; r <= 8; r++) begin
			load_reg(5'(r), $urandom());
		end
		for (int k = 0; k < 8; k++) begin
			send(enc_r(7'h00, rand_src(), rand_src(), k[2:0], 5'(10 + k)));
		end
		send(enc_r(7'h20, rand_src(), rand_src(), 3'b000, 5'd18));
		send(enc_r(7'h20, rand_src(), rand_src(), 3'b101, 5'd19));
		for (int k = 0; k < 8; k++) begin
			imm = (k == 1 || k == 5) ? {7'h00, 5'($urandom())} : 12'($urandom());
			send(enc_i(imm, rand_src(), k[2:0], 5'(20 + k), exec_pkg::OPC_OP_IMM));
		end
		send(enc_i({7'h20, 5'($urandom())}, rand_src(), 3'b101, 5'd28, exec_pkg::OPC_OP_IMM));
		send({20'($urandom()), 5'd29, exec_pkg::OPC_AUIPC});
		check_regs();
	endtask

	task automatic test_bypass();
		load_reg(5'd1, $urandom());
		load_reg(5'd2, $urandom());
		for (int k = 0; k < 12; k++) begin
			send(enc_i(12'($urandom()), 5'd1, 3'b000, 5'd1, exec_pkg::OPC_OP_IMM));
			send(enc_r(7'h00, 5'd1, 5'd2, 3'b100, 5'd2));
			send(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd1));
		end
		wait_drain();
	endtask

	task automatic test_backpressure();
		bp_enable = 1'b1;
		for (int k = 0; k < 40; k++) begin
			if (k % 4 == 3) begin
				send(enc_i(12'($urandom()), 5'($urandom_range(1, 15)), 3'b000,
				           5'($urandom_range(1, 15)), exec_pkg::OPC_OP_IMM));
			end else begin
				send(enc_r(7'h00, 5'($urandom_range(0, 15)), 5'($urandom_range(0, 15)),
				           3'($urandom_range(0, 7)), 5'($urandom_range(1, 15))));
			end
		end
		wait_drain();
		bp_enable = 1'b0;
		@(negedge clk);
	endtask

	task automatic test_control();
		load_reg(5'd1, 32'hffff_fffb);
		load_reg(5'd2, 32'd3);
		// Each condition once taken, then once not taken.
		send(enc_b({12'($urandom()), 1'b0}, 5'd1, 5'd1, 3'b000));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd1, 3'b000));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd1, 3'b001));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd2, 3'b001));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd1, 3'b100));
		send(enc_b({12'($urandom()), 1'b0}, 5'd1, 5'd2, 3'b100));
		send(enc_b({12'($urandom()), 1'b0}, 5'd1, 5'd2, 3'b101));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd1, 3'b101));
		send(enc_b({12'($urandom()), 1'b0}, 5'd1, 5'd2, 3'b110));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd1, 3'b110));
		send(enc_b({12'($urandom()), 1'b0}, 5'd2, 5'd1, 3'b111));
		send(enc_b({12'($urandom()), 1'b0}, 5'd1, 5'd2, 3'b111));
		send(enc_j({20'($urandom()), 1'b0}, 5'd9));
		send(enc_j({20'($urandom()), 1'b0}, 5'd0));
		load_reg(5'd3, $urandom());
		send(enc_i(12'($urandom()), 5'd3, 3'b000, 5'd11, exec_pkg::OPC_JALR));
		// The sum is odd so bit 0 of the target is dropped.
		load_reg(5'd3, 32'h0000_2000);
		send(enc_i(12'h7ff, 5'd3, 3'b000, 5'd12, exec_pkg::OPC_JALR));
		check_regs();
	endtask

	task automatic test_nonwrite();
		send(enc_i(12'd123, 5'd0, 3'b000, 5'd0, exec_pkg::OPC_OP_IMM));
		send(enc_r(7'h00, 5'd5, 5'd4, 3'b000, 5'd0));
		send(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd13));
		send({20'($urandom()), 5'd5, 7'b0000011});
		send(32'h0000_0073);
		check_regs();
	endtask

	initial begin
		void'($urandom(32'h997e_489b));
		$timeformat(-9, 0, " ns", 0);
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr_word  = '0;
		instr_pc    = '0;
		retire_ready = 1'b1;
		bp_enable   = 1'b0;
		held_valid  = 1'b0;
		pc_next     = 32'h0000_1000;
		stretch     = 0;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		for (int r = 0; r < 32; r++) begin
			xr[r] = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_reset();
		test_arith();
		test_bypass();
		test_backpressure();
		test_control();
		test_nonwrite();
		finish_run();
	end

endmodule

// ==== sources.f ====
hdl/exec_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/retire_stage.sv
hdl/exec_core.sv
test/tb_exec_core.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  # Package first, then the blocks, then the top level.
  - hdl/exec_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/reg_file.sv
  - hdl/int_alu.sv
  - hdl/branch_unit.sv
  - hdl/retire_stage.sv
  - hdl/exec_core.sv

  - target: test
    files:
      - test/tb_exec_core.sv
